// File: Bender.yml
package:
  name: boot_subsys

sources:
  - src/boot_pkg.sv
  - src/bootrom.sv
  - src/clint_msip.sv
  - src/soc_ctrl_regs.sv
  - src/obi_addr_demux.sv
  - src/boot_subsys.sv
  - target: test
    files:
      - sim/tb_boot_subsys.sv

// File: compile.f
src/boot_pkg.sv
src/bootrom.sv
src/clint_msip.sv
src/soc_ctrl_regs.sv
src/obi_addr_demux.sv
src/boot_subsys.sv
sim/tb_boot_subsys.sv

// File: sim/tb_boot_subsys.sv
// self-checking testbench for boot_subsys; expects gnt tied high and every response one cycle after req
module tb_boot_subsys;
	import boot_pkg::*;

	localparam int TIMEOUT_CYC = 1000; // 10 reset + ~300 traffic cycles, with margin

	// what one response should look like
	typedef struct packed {
		id_t   rid;
		data_t rdata;
		logic  err;
		logic  msip;   // msip_o in the response cycle
	} exp_t;

	logic     clk;
	logic     rst_n;
	obi_req_t bus_req;
	obi_rsp_t bus_rsp;
	logic     msip;

	exp_t  exp_q[$];       // expected responses in issue order
	logic  owed;           // a request was accepted at the last edge
	int    value_errs;
	int    proto_errs;
	int    cycle_cnt;
	int    seed;
	logic  shadow_msip;    // reference copy of the msip bit
	data_t shadow_boot;    // reference copy of the boot address

	boot_subsys boot_subsys_inst (
		.clk_i     (clk),
		.rst_n_i   (rst_n),
		.obi_req_i (bus_req),
		.obi_rsp_o (bus_rsp),
		.msip_o    (msip)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYC) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("=== FAIL ===");
		$finish;
	end

	// expected rdata/err from the memory map, updates the shadow state on writes
	function automatic exp_t ref_access(addr_t addr, logic we, be_t be, data_t wdata);
		exp_t  e;
		addr_t offs;
		addr_t word;
		e       = '0;
		offs    = addr & ~REGION_MASK;
		word    = offs >> 2;
		e.err   = 1'b1;     // anything not matched below is an error
		e.rdata = ERR_DATA;
		if ((addr & REGION_MASK) == ROM_BASE) begin
			if (!we && word < ROM_WORDS) begin // rom is read-only
				e.err   = 1'b0;
				e.rdata = ROM_DATA[word];
			end
		end else if ((addr & REGION_MASK) == CLINT_BASE) begin
			if (word == 0) begin
				if (we && be[0]) shadow_msip = wdata[0];
				e.err   = 1'b0;
				e.rdata = {31'b0, shadow_msip};
			end
		end else if ((addr & REGION_MASK) == SOC_CTRL_BASE) begin
			if (word == 0) begin
				if (we) begin
					for (int b = 0; b < 4; b++) begin
						if (be[b]) shadow_boot[8*b +: 8] = wdata[8*b +: 8];
					end
				end
				e.err   = 1'b0;
				e.rdata = shadow_boot; // write answers with the new value
			end
		end
		e.msip = shadow_msip;
		return e;
	endfunction

	// drive one request on the falling edge and queue its expected response
	task automatic issue_access(input addr_t addr, input logic we, input be_t be,
			input data_t wdata, input id_t aid);
		exp_t e;
		@(negedge clk);
		bus_req.req     = 1'b1;
		bus_req.a.addr  = addr;
		bus_req.a.we    = we;
		bus_req.a.be    = be;
		bus_req.a.wdata = wdata;
		bus_req.a.aid   = aid;
		e     = ref_access(addr, we, be, wdata);
		e.rid = aid;
		exp_q.push_back(e);
	endtask

	task automatic go_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			bus_req.req = 1'b0;
		end
	endtask

	task automatic drain_responses();
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	// random mix over all regions, with idle gaps
	task automatic run_random(input int count);
		int    pick;
		addr_t addr;
		logic  we;
		be_t   be;
		data_t wdata;
		id_t   aid;
		for (int n = 0; n < count; n++) begin
			pick = $unsigned($random(seed)) % 8;
			case (pick)
				0, 1: addr = ROM_BASE | ($random(seed) & 32'h3F);   // words 0..15
				2:    addr = ROM_BASE | ($random(seed) & 32'hFFFF); // mostly far offsets
				3, 4: addr = CLINT_BASE | ($random(seed) & 32'h7);  // msip or offset 4
				5, 6: addr = SOC_CTRL_BASE | ($random(seed) & 32'h7);
				default: addr = $random(seed);                      // almost always unmapped
			endcase
			we    = 1'($random(seed));
			be    = be_t'($random(seed));
			wdata = $random(seed);
			aid   = id_t'($random(seed));
			issue_access(addr, we, be, wdata, aid);
			if (($random(seed) & 3) == 0) go_idle(1 + $unsigned($random(seed)) % 3);
		end
	endtask

	// response checker, samples on the rising edge
	always @(posedge clk) begin
		exp_t e;
		if (!rst_n) begin
			owed = 1'b0;
		end else begin
			if (bus_rsp.rvalid) begin
				if (exp_q.size() == 0) begin
					proto_errs++;
					$display("response arrived with no request outstanding, cycle %0d", cycle_cnt);
				end else begin
					e = exp_q.pop_front();
					if (bus_rsp.r.rid !== e.rid) begin
						value_errs++;
						$display("Fail obi_rsp_o.r.rid: got %h expected %h", bus_rsp.r.rid, e.rid);
					end
					if (bus_rsp.r.rdata !== e.rdata) begin
						value_errs++;
						$display("Fail obi_rsp_o.r.rdata: got %h expected %h (rid %h)",
							bus_rsp.r.rdata, e.rdata, e.rid);
					end
					if (bus_rsp.r.err !== e.err) begin
						value_errs++;
						$display("Fail obi_rsp_o.r.err: got %h expected %h (rid %h)",
							bus_rsp.r.err, e.err, e.rid);
					end
					if (msip !== e.msip) begin
						value_errs++;
						$display("Fail msip_o: got %h expected %h (rid %h)", msip, e.msip, e.rid);
					end
				end
			end else if (owed) begin
				proto_errs++;
				$display("no response one cycle after an accepted request, cycle %0d", cycle_cnt);
				if (exp_q.size() != 0) e = exp_q.pop_front(); // keep later checks in step
			end
			if (bus_req.req && bus_rsp.gnt !== 1'b1) begin
				proto_errs++;
				$display("request was not granted, cycle %0d", cycle_cnt);
			end
			owed = bus_req.req;
		end
	end

	initial begin
		seed        = 32'heb92_5926;
		value_errs  = 0;
		proto_errs  = 0;
		owed        = 1'b0;
		bus_req     = '0;
		// msip write held through reset, reset must win
		bus_req.req     = 1'b1;
		bus_req.a.addr  = CLINT_BASE;
		bus_req.a.we    = 1'b1;
		bus_req.a.be    = 4'hF;
		bus_req.a.wdata = 32'h1;
		rst_n       = 1'b0;
		shadow_msip = 1'b0;
		shadow_boot = BOOT_ADDR_RST;
		repeat (10) @(posedge clk);
		@(negedge clk);
		if (bus_rsp.rvalid !== 1'b0 || msip !== 1'b0) begin
			proto_errs++;
			$display("rvalid or msip_o not low after reset");
		end
		bus_req = '0;
		rst_n   = 1'b1;
		@(negedge clk);

		// whole trampoline, back to back
		for (int i = 0; i < ROM_WORDS; i++) begin
			issue_access(ROM_BASE + 4 * i, 1'b0, 4'hF, '0, id_t'(i));
		end
		go_idle(2);

		// rom write and reads past the image
		issue_access(ROM_BASE + 32'h8, 1'b1, 4'hF, 32'hDEAD_BEEF, 4'h1);
		issue_access(ROM_BASE + 32'h24, 1'b0, 4'hF, '0, 4'h2); // word 9
		issue_access(ROM_BASE + 32'h3C, 1'b0, 4'hF, '0, 4'h3); // word 15
		issue_access(ROM_BASE + 32'h100, 1'b0, 4'hF, '0, 4'h4);
		go_idle(2);

		// msip set, readback, clear, bad offset
		issue_access(CLINT_BASE, 1'b1, 4'hF, 32'h1, 4'h5);
		issue_access(CLINT_BASE, 1'b0, 4'hF, '0, 4'h6);
		issue_access(CLINT_BASE, 1'b1, 4'hF, 32'h0, 4'h7);
		issue_access(CLINT_BASE, 1'b0, 4'hF, '0, 4'h8);
		issue_access(CLINT_BASE + 32'h4, 1'b0, 4'hF, '0, 4'h9);
		go_idle(2);

		// boot address: reset value, then lane writes each followed at once by a read
		issue_access(SOC_CTRL_BASE, 1'b0, 4'hF, '0, 4'hA);
		issue_access(SOC_CTRL_BASE, 1'b1, 4'b0001, 32'h1234_5678, 4'hB);
		issue_access(SOC_CTRL_BASE, 1'b0, 4'hF, '0, 4'hC);
		issue_access(SOC_CTRL_BASE, 1'b1, 4'b1010, 32'hA5A5_A5A5, 4'hD);
		issue_access(SOC_CTRL_BASE, 1'b0, 4'hF, '0, 4'hE);
		issue_access(SOC_CTRL_BASE + 32'h8, 1'b1, 4'hF, 32'hFFFF_FFFF, 4'hF);
		issue_access(SOC_CTRL_BASE, 1'b0, 4'hF, '0, 4'h0);
		go_idle(2);

		// holes in the map
		issue_access(32'h0000_0000, 1'b0, 4'hF, '0, 4'h3);
		issue_access(32'h0201_0000, 1'b0, 4'hF, '0, 4'h6);
		issue_access(32'h0301_0000, 1'b1, 4'hF, 32'h55AA_55AA, 4'h9);
		issue_access(32'hFFFF_FFFC, 1'b0, 4'hF, '0, 4'hC);
		go_idle(2);

		run_random(200);
		go_idle(1);
		drain_responses();
		go_idle(2);

		$display("errors: value %0d, protocol %0d", value_errs, proto_errs);
		if (value_errs + proto_errs == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: src/boot_pkg.sv
// fixed 32-bit OBI with 4-bit ids, one manager, 64 KiB regions; map and rom image cannot be changed per instance
package boot_pkg;

	localparam int unsigned ADDR_W = 32; // byte address
	localparam int unsigned DATA_W = 32; // one word per beat
	localparam int unsigned ID_W   = 4;  // transaction id, echoed back as rid

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [DATA_W-1:0]   data_t;
	typedef logic [ID_W-1:0]     id_t;
	typedef logic [DATA_W/8-1:0] be_t;   // one bit per byte lane

	// request channel payload
	typedef struct packed {
		addr_t addr;
		logic  we;    // 1 = write
		be_t   be;
		data_t wdata;
		id_t   aid;
	} obi_a_t;

	typedef struct packed {
		logic   req;
		obi_a_t a;
	} obi_req_t;

	// response channel payload
	typedef struct packed {
		data_t rdata;
		id_t   rid;
		logic  err;   // decode error, rom write or bad offset
	} obi_r_t;

	typedef struct packed {
		logic   gnt;    // tied high by every target
		logic   rvalid; // one cycle after the accepted request
		obi_r_t r;
	} obi_rsp_t;

	// memory map, compared under REGION_MASK
	localparam addr_t ROM_BASE      = 32'h0200_0000;
	localparam addr_t CLINT_BASE    = 32'h0204_0000;
	localparam addr_t SOC_CTRL_BASE = 32'h0300_0000;
	localparam addr_t REGION_MASK   = 32'hFFFF_0000;

	// decoder target select
	typedef logic [1:0] tgt_sel_t;
	localparam tgt_sel_t TGT_ROM   = 2'd0;
	localparam tgt_sel_t TGT_CLINT = 2'd1;
	localparam tgt_sel_t TGT_CTRL  = 2'd2;
	localparam tgt_sel_t TGT_NONE  = 2'd3;  // unmapped, answered by the decoder

	localparam int unsigned ROM_WORDS = 9;
	localparam int unsigned ROM_AW    = 6;  // byte offset bits inside the rom window
	typedef logic [ROM_AW-3:0] rom_idx_t;   // word index

	// wfi trampoline: sleep until msip, clear it, jump to the boot address
	localparam data_t ROM_DATA [ROM_WORDS] = '{
		32'h00800293, // t0 = msie mask
		32'h30429073, // mie <= t0
		32'h10500073, // wait for interrupt
		32'h020402b7, // t0 = CLINT_BASE
		32'h0002a023, // msip <= 0
		32'h30401073, // mie <= 0
		32'h030002b7, // t0 = SOC_CTRL_BASE
		32'h0002a283, // t0 = boot address
		32'h00028067  // jump
	};

	localparam data_t ERR_DATA      = 32'hBADC_AB1E; // rdata on every error
	localparam addr_t BOOT_ADDR_RST = 32'h8000_0000; // boot address after reset

endpackage

// File: src/boot_subsys.sv
// boot path of the soc: one OBI manager port, fixed map, 1-cycle responses for every address
module boot_subsys (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  boot_pkg::obi_req_t obi_req_i,
	output boot_pkg::obi_rsp_t obi_rsp_o,
	output logic               msip_o      // software interrupt toward the core
);
	import boot_pkg::*;

	// decoder to target links
	obi_req_t rom_req;
	obi_rsp_t rom_rsp;
	obi_req_t clint_req;
	obi_rsp_t clint_rsp;
	obi_req_t ctrl_req;
	obi_rsp_t ctrl_rsp;

	obi_addr_demux demux_inst (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.mgr_req_i   (obi_req_i),
		.mgr_rsp_o   (obi_rsp_o),
		.rom_req_o   (rom_req),
		.rom_rsp_i   (rom_rsp),
		.clint_req_o (clint_req),
		.clint_rsp_i (clint_rsp),
		.ctrl_req_o  (ctrl_req),
		.ctrl_rsp_i  (ctrl_rsp)
	);

	// trampoline at ROM_BASE
	bootrom bootrom_inst (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.obi_req_i (rom_req),
		.obi_rsp_o (rom_rsp)
	);

	// wakes the core out of wfi
	clint_msip clint_inst (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.obi_req_i (clint_req),
		.obi_rsp_o (clint_rsp),
		.msip_o    (msip_o)
	);

	soc_ctrl_regs soc_ctrl_inst (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.obi_req_i (ctrl_req),
		.obi_rsp_o (ctrl_rsp)
	);

endmodule

// File: src/bootrom.sv
// read-only 9-word trampoline, always grants, answers one cycle later; writes and offsets past word 8 give err
module bootrom (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  boot_pkg::obi_req_t obi_req_i,
	output boot_pkg::obi_rsp_t obi_rsp_o
);
	import boot_pkg::*;

	logic     req_q;      // response owed this cycle
	logic     we_q;       // that request was a write
	id_t      id_q;
	rom_idx_t idx_q;      // word index of that request
	logic     far_q;      // offset outside the 64-byte window
	addr_t    offs;       // byte offset inside the region
	logic     far_d;
	logic     in_range;

	assign offs  = obi_req_i.a.addr & ~REGION_MASK;
	assign far_d = |(offs >> ROM_AW); // any bit above the window set

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			req_q <= 1'b0;
		end else begin
			req_q <= obi_req_i.req;
		end
	end

	// request fields carried into the response cycle
	always_ff @(posedge clk_i) begin
		we_q  <= obi_req_i.a.we;
		id_q  <= obi_req_i.a.aid;
		idx_q <= offs[ROM_AW-1:2];
		far_q <= far_d;
	end

	assign in_range = !far_q && (idx_q < ROM_WORDS); // 9..15 unmapped too

	always_comb begin
		obi_rsp_o        = '0;
		obi_rsp_o.gnt    = 1'b1;  // never stalls
		obi_rsp_o.rvalid = req_q;
		obi_rsp_o.r.rid  = id_q;
		obi_rsp_o.r.err  = we_q || !in_range;
		// rom data only for a legal read
		obi_rsp_o.r.rdata = obi_rsp_o.r.err ? ERR_DATA : ROM_DATA[idx_q];
	end

	// a write is answered next cycle, and always as an error
	a_write_err: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(obi_req_i.req && obi_req_i.a.we) |=> (obi_rsp_o.rvalid && obi_rsp_o.r.err));

endmodule

// File: src/clint_msip.sv
// only the msip word at offset 0 exists; other offsets in the region answer with err, no mtime
module clint_msip (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  boot_pkg::obi_req_t obi_req_i,
	output boot_pkg::obi_rsp_t obi_rsp_o,
	output logic               msip_o
);
	import boot_pkg::*;

	logic msip_q;   // software interrupt pending
	logic hit;      // word 0 of the region addressed
	logic wr_en;
	logic req_q;
	logic hit_q;
	id_t  id_q;

	assign hit   = (obi_req_i.a.addr & ~REGION_MASK & ~addr_t'(3)) == '0;
	assign wr_en = obi_req_i.req && obi_req_i.a.we && hit && obi_req_i.a.be[0];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			msip_q <= 1'b0;
			req_q  <= 1'b0;
		end else begin
			req_q <= obi_req_i.req;
			if (wr_en) msip_q <= obi_req_i.a.wdata[0]; // takes effect on the accepting edge
		end
	end

	always_ff @(posedge clk_i) begin
		hit_q <= hit;
		id_q  <= obi_req_i.a.aid;
	end

	assign msip_o = msip_q;

	always_comb begin
		obi_rsp_o         = '0;
		obi_rsp_o.gnt     = 1'b1;
		obi_rsp_o.rvalid  = req_q;
		obi_rsp_o.r.rid   = id_q;
		obi_rsp_o.r.err   = !hit_q;                          // bad offset
		obi_rsp_o.r.rdata = hit_q ? data_t'(msip_q) : ERR_DATA; // msip in bit 0
	end

	// interrupt line moves only after a write, or when reset clears it
	a_msip_on_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$changed(msip_o) |-> $past(!rst_n_i || (obi_req_i.req && obi_req_i.a.we)));

endmodule

// File: src/obi_addr_demux.sv
// one manager to rom/clint/soc_ctrl, targets must answer exactly one cycle after req; unmapped gets err
module obi_addr_demux (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  boot_pkg::obi_req_t mgr_req_i,
	output boot_pkg::obi_rsp_t mgr_rsp_o,
	output boot_pkg::obi_req_t rom_req_o,
	input  boot_pkg::obi_rsp_t rom_rsp_i,
	output boot_pkg::obi_req_t clint_req_o,
	input  boot_pkg::obi_rsp_t clint_rsp_i,
	output boot_pkg::obi_req_t ctrl_req_o,
	input  boot_pkg::obi_rsp_t ctrl_rsp_i
);
	import boot_pkg::*;

	addr_t    region;   // upper address bits of the request
	tgt_sel_t sel_d;    // target addressed now
	tgt_sel_t sel_q;    // target owing the response
	logic     req_q;    // a request was accepted last cycle
	id_t      aid_q;    // its id, for the decode error

	assign region = mgr_req_i.a.addr & REGION_MASK;

	always_comb begin
		if (region == ROM_BASE) begin
			sel_d = TGT_ROM;
		end else if (region == CLINT_BASE) begin
			sel_d = TGT_CLINT;
		end else if (region == SOC_CTRL_BASE) begin
			sel_d = TGT_CTRL;
		end else begin
			sel_d = TGT_NONE;   // nobody sees this request
		end
	end

	// every target sees the payload, only the selected one sees req
	always_comb begin
		rom_req_o       = mgr_req_i;
		clint_req_o     = mgr_req_i;
		ctrl_req_o      = mgr_req_i;
		rom_req_o.req   = mgr_req_i.req && (sel_d == TGT_ROM);
		clint_req_o.req = mgr_req_i.req && (sel_d == TGT_CLINT);
		ctrl_req_o.req  = mgr_req_i.req && (sel_d == TGT_CTRL);
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			req_q <= 1'b0;
			sel_q <= TGT_NONE;
		end else begin
			req_q <= mgr_req_i.req;
			sel_q <= sel_d;
		end
	end

	always_ff @(posedge clk_i) begin
		aid_q <= mgr_req_i.a.aid;
	end

	always_comb begin
		// response side follows last cycle's selection
		case (sel_q)
			TGT_ROM:   mgr_rsp_o = rom_rsp_i;
			TGT_CLINT: mgr_rsp_o = clint_rsp_i;
			TGT_CTRL:  mgr_rsp_o = ctrl_rsp_i;
			default: begin
				mgr_rsp_o         = '0;
				mgr_rsp_o.rvalid  = req_q;
				mgr_rsp_o.r.rdata = ERR_DATA;
				mgr_rsp_o.r.rid   = aid_q;   // echo aid
				mgr_rsp_o.r.err   = 1'b1;
			end
		endcase
		// grant comes from the target addressed this cycle
		case (sel_d)
			TGT_ROM:   mgr_rsp_o.gnt = rom_rsp_i.gnt;
			TGT_CLINT: mgr_rsp_o.gnt = clint_rsp_i.gnt;
			TGT_CTRL:  mgr_rsp_o.gnt = ctrl_rsp_i.gnt;
			default:   mgr_rsp_o.gnt = 1'b1;  // decoder itself accepts
		endcase
	end

	a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({rom_req_o.req, clint_req_o.req, ctrl_req_o.req}));

	// targets must not answer without a request a cycle earlier
	a_rvalid_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$rose(mgr_rsp_o.rvalid) |-> $past(mgr_req_i.req));

endmodule

// File: src/soc_ctrl_regs.sv
// single boot-address register at offset 0, byte-lane writes, other offsets answer with err
module soc_ctrl_regs (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  boot_pkg::obi_req_t obi_req_i,
	output boot_pkg::obi_rsp_t obi_rsp_o
);
	import boot_pkg::*;

	data_t boot_addr_q;   // where the trampoline jumps
	logic  hit;           // offset 0 addressed
	logic  wr_en;
	logic  req_q;
	logic  hit_q;
	id_t   id_q;

	assign hit   = (obi_req_i.a.addr & ~REGION_MASK & ~addr_t'(3)) == '0;
	assign wr_en = obi_req_i.req && obi_req_i.a.we && hit;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			boot_addr_q <= data_t'(BOOT_ADDR_RST);
		end else if (wr_en) begin
			// only the enabled lanes change
			for (int i = 0; i < DATA_W / 8; i++) begin
				if (obi_req_i.a.be[i]) begin
					boot_addr_q[8*i +: 8] <= obi_req_i.a.wdata[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			req_q <= 1'b0;
		end else begin
			req_q <= obi_req_i.req; // response owed next cycle
		end
	end

	always_ff @(posedge clk_i) begin
		hit_q <= hit;
		id_q  <= obi_req_i.a.aid;
	end

	// response reads the register after the write edge, so a write echoes its new value
	always_comb begin
		obi_rsp_o         = '0;
		obi_rsp_o.gnt     = 1'b1;
		obi_rsp_o.rvalid  = req_q;
		obi_rsp_o.r.rid   = id_q;
		obi_rsp_o.r.err   = !hit_q;
		obi_rsp_o.r.rdata = hit_q ? boot_addr_q : ERR_DATA;
	end

endmodule
